/* hw/refillPkg.sv */
package refillPkg;

    //////////////////////////////////////////////////
    // line geometry
    //////////////////////////////////////////////////

    // eight words per line, wrap order within the line
    localparam int wordsPerLine = 8;
    // word within the line
    localparam int offsetBits = 3;

    //////////////////////////////////////////////////
    // data types
    //////////////////////////////////////////////////

    // word address, low offsetBits select the word
    typedef logic [31:0] wordAddrT;

    // one data word
    typedef logic [31:0] wordT;

    // whole line, word 0 in the lowest bits
    typedef logic [wordsPerLine*32-1:0] lineT;

    // requester side
    typedef struct packed {
        wordAddrT addr;
    } reqT;

    // response back to requester
    // hit clear means forwarded critical word
    typedef struct packed {
        wordT data;
        logic hit;
    } rspT;

    //////////////////////////////////////////////////
    // controller states
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        idle,
        lookup,
        fill,
        install
    } ctrlStateT;

endpackage

/* hw/refillCtrl.sv */
module refillCtrl (
    input  logic                Clk,
    input  logic                reset,
    input  logic                reqValid,
    input  refillPkg::reqT      req,
    input  logic                hit,
    input  refillPkg::wordT     hitWord,
    input  logic                criticalValid,
    input  refillPkg::wordT     criticalWord,
    input  logic                lineDone,
    output logic                rspValid,
    output refillPkg::rspT      rsp,
    output refillPkg::wordAddrT lookupAddr,
    output logic                memRead,
    output refillPkg::wordAddrT memAddr,
    output logic                fillStart,
    output refillPkg::wordAddrT fillAddr,
    output logic                installEn
);

    refillPkg::ctrlStateT state;
    // request currently owning the refill path
    refillPkg::reqT       curReq;
    // one entry for a request arriving mid fill
    refillPkg::reqT       slotReq;
    logic                 slotFull;
    logic                 burstStart;
    logic                 hitRspValid;
    refillPkg::wordT      hitRspData;
    logic                 lookupActive;
    logic                 holdWindow;

    //////////////////////////////////////////////////
    // lookup side
    //////////////////////////////////////////////////

    // held request is replayed from the slot
    assign lookupAddr = (state == refillPkg::lookup) ? slotReq.addr : req.addr;

    // store is consulted this cycle
    assign lookupActive = (state == refillPkg::lookup) ||
                          (state == refillPkg::idle && reqValid);

    // new requests get parked while a line is in flight
    assign holdWindow = (state == refillPkg::fill) || (state == refillPkg::install);

    //////////////////////////////////////////////////
    // outputs toward memory and buffer
    //////////////////////////////////////////////////

    // burst always starts at the missed word
    assign memRead   = burstStart;
    assign memAddr   = curReq.addr;
    assign fillStart = burstStart;
    assign fillAddr  = curReq.addr;

    // hit answers are registered
    // miss answers come straight from the buffer's critical word
    assign rspValid = hitRspValid | criticalValid;
    assign rsp.data = criticalValid ? criticalWord : hitRspData;
    assign rsp.hit  = hitRspValid;

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (reset) begin
            state       <= refillPkg::idle;
            slotFull    <= 1'b0;
            burstStart  <= 1'b0;
            hitRspValid <= 1'b0;
            installEn   <= 1'b0;
        end else begin
            // strobes default low
            burstStart  <= 1'b0;
            hitRspValid <= 1'b0;
            installEn   <= 1'b0;
            case (state)
                refillPkg::idle,
                refillPkg::lookup: begin
                    state    <= refillPkg::idle;
                    // slot consumed by the lookup
                    slotFull <= 1'b0;
                    if (lookupActive && hit) begin
                        hitRspValid <= 1'b1;
                    end else if (lookupActive) begin
                        burstStart <= 1'b1;
                        state      <= refillPkg::fill;
                    end
                end
                refillPkg::fill: begin
                    // line complete in buffer
                    if (lineDone) begin
                        installEn <= 1'b1;
                        state     <= refillPkg::install;
                    end
                end
                refillPkg::install: begin
                    // line written at end of this cycle
                    if (slotFull || reqValid) begin
                        state <= refillPkg::lookup;
                    end else begin
                        state <= refillPkg::idle;
                    end
                end
                default: begin
                    state <= refillPkg::idle;
                end
            endcase
            if (reqValid && holdWindow) begin
                slotFull <= 1'b1;
            end
        end
    end

    // payload registers
    always_ff @(posedge Clk) begin
        if (lookupActive) begin
            curReq.addr <= lookupAddr;
            hitRspData  <= hitWord;
        end
        if (reqValid && holdWindow) begin
            slotReq <= req;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // requester allows at most one request per fill
    slotOverrun: assert property (@(posedge Clk) disable iff (reset)
        reqValid |-> !slotFull)
        else $error("request while hold slot is full");

    // buffer forwards only while a fill is open
    critOutsideFill: assert property (@(posedge Clk) disable iff (reset)
        criticalValid |-> state == refillPkg::fill)
        else $error("critical word outside fill");

endmodule

/* hw/linefillBuffer.sv */
module linefillBuffer (
    input  logic                Clk,
    input  logic                reset,
    input  logic                fillStart,
    input  refillPkg::wordAddrT fillAddr,
    input  logic                memBeatValid,
    input  refillPkg::wordT     memBeatData,
    output logic                criticalValid,
    output refillPkg::wordT     criticalWord,
    output logic                lineDone,
    output refillPkg::lineT     line,
    output refillPkg::wordAddrT lineAddr
);

    typedef logic [refillPkg::offsetBits-1:0] offsetT;

    localparam int WordBits = $bits(refillPkg::wordT);

    // fill in progress
    logic                active;
    offsetT              beatCount;
    offsetT              slotIdx;
    logic                beatTaken;
    logic                firstBeat;
    logic                lastBeat;
    refillPkg::wordAddrT startAddr;
    refillPkg::wordT     wordBuf [refillPkg::wordsPerLine];
    refillPkg::lineT     nextLine;

    assign beatTaken = active && memBeatValid;
    assign firstBeat = beatTaken && (beatCount == '0);
    assign lastBeat  = beatTaken && (beatCount == offsetT'(refillPkg::wordsPerLine - 1));

    // wrap order, offset plus beat number modulo 8
    assign slotIdx = startAddr[refillPkg::offsetBits-1:0] + beatCount;

    // line as it stands including the beat on the bus
    always_comb begin
        for (int i = 0; i < refillPkg::wordsPerLine; i++) begin
            nextLine[i*WordBits +: WordBits] = wordBuf[i];
        end
        nextLine[slotIdx*WordBits +: WordBits] = memBeatData;
    end

    //////////////////////////////////////////////////
    // beat counting
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (reset) begin
            active        <= 1'b0;
            beatCount     <= '0;
            criticalValid <= 1'b0;
            lineDone      <= 1'b0;
        end else begin
            // one cycle after the beats that cause them
            criticalValid <= firstBeat;
            lineDone      <= lastBeat;
            if (fillStart) begin
                active    <= 1'b1;
                beatCount <= '0;
            end else if (beatTaken) begin
                beatCount <= beatCount + 1'b1;
                if (lastBeat) begin
                    active <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // data path
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (fillStart) begin
            startAddr <= fillAddr;
        end
        if (beatTaken) begin
            wordBuf[slotIdx] <= memBeatData;
        end
        // first beat is the missed word
        if (firstBeat) begin
            criticalWord <= memBeatData;
        end
        if (lastBeat) begin
            line     <= nextLine;
            // line base, offset cleared
            lineAddr <= startAddr & ~refillPkg::wordAddrT'(refillPkg::wordsPerLine - 1);
        end
    end

    // beats only between fillStart and the eighth beat
    strayBeat: assert property (@(posedge Clk) disable iff (reset)
        memBeatValid |-> active)
        else $error("memory beat outside a burst");

endmodule

/* hw/lineStore.sv */
module lineStore #(
    parameter int NumSets = 16
) (
    input  logic                Clk,
    input  logic                reset,
    input  refillPkg::wordAddrT lookupAddr,
    input  logic                installEn,
    input  refillPkg::wordAddrT lineAddr,
    input  refillPkg::lineT     line,
    output logic                hit,
    output refillPkg::wordT     hitWord
);

    localparam int AddrBits = $bits(refillPkg::wordAddrT);
    localparam int WordBits = $bits(refillPkg::wordT);
    localparam int SetBits  = $clog2(NumSets);
    // whatever is left above set and offset
    localparam int TagBits  = AddrBits - refillPkg::offsetBits - SetBits;

    typedef logic [SetBits-1:0]               setIdxT;
    typedef logic [TagBits-1:0]               tagT;
    typedef logic [refillPkg::offsetBits-1:0] offsetT;

    //////////////////////////////////////////////////
    // arrays
    //////////////////////////////////////////////////

    logic [NumSets-1:0] validBits;
    tagT                tagArr  [NumSets];
    refillPkg::lineT    lineArr [NumSets];

    // lookup fields
    setIdxT          lookupSet;
    tagT             lookupTag;
    offsetT          lookupOffset;
    refillPkg::lineT storedLine;

    // install fields
    setIdxT installSet;
    tagT    installTag;

    assign lookupSet    = lookupAddr[refillPkg::offsetBits +: SetBits];
    assign lookupTag    = lookupAddr[AddrBits-1 -: TagBits];
    assign lookupOffset = lookupAddr[refillPkg::offsetBits-1:0];

    assign installSet = lineAddr[refillPkg::offsetBits +: SetBits];
    assign installTag = lineAddr[AddrBits-1 -: TagBits];

    //////////////////////////////////////////////////
    // hit detection
    //////////////////////////////////////////////////

    assign storedLine = lineArr[lookupSet];
    assign hit        = validBits[lookupSet] && (tagArr[lookupSet] == lookupTag);
    // word select by offset
    assign hitWord    = storedLine[lookupOffset*WordBits +: WordBits];

    //////////////////////////////////////////////////
    // install
    //////////////////////////////////////////////////

    // valid bits are control state
    always_ff @(posedge Clk) begin
        if (reset) begin
            validBits <= '0;
        end else if (installEn) begin
            validBits[installSet] <= 1'b1;
        end
    end

    // tag and data written together, old line dropped
    always_ff @(posedge Clk) begin
        if (installEn) begin
            tagArr[installSet]  <= installTag;
            lineArr[installSet] <= line;
        end
    end

endmodule

/* hw/refillTop.sv */
module refillTop #(
    parameter int NumSets = 16
) (
    input  logic                Clk,
    input  logic                reset,
    input  logic                reqValid,
    input  refillPkg::reqT      req,
    output logic                rspValid,
    output refillPkg::rspT      rsp,
    output logic                memRead,
    output refillPkg::wordAddrT memAddr,
    input  logic                memBeatValid,
    input  refillPkg::wordT     memBeatData
);

    // controller to store
    refillPkg::wordAddrT lookupAddr;
    logic                hit;
    refillPkg::wordT     hitWord;
    logic                installEn;

    // controller to buffer
    logic                fillStart;
    refillPkg::wordAddrT fillAddr;

    // buffer results
    logic                criticalValid;
    refillPkg::wordT     criticalWord;
    logic                lineDone;
    refillPkg::lineT     line;
    refillPkg::wordAddrT lineAddr;

    refillCtrl i_refillCtrl (
        .Clk           (Clk),
        .reset         (reset),
        .reqValid      (reqValid),
        .req           (req),
        .hit           (hit),
        .hitWord       (hitWord),
        .criticalValid (criticalValid),
        .criticalWord  (criticalWord),
        .lineDone      (lineDone),
        .rspValid      (rspValid),
        .rsp           (rsp),
        .lookupAddr    (lookupAddr),
        .memRead       (memRead),
        .memAddr       (memAddr),
        .fillStart     (fillStart),
        .fillAddr      (fillAddr),
        .installEn     (installEn)
    );

    linefillBuffer i_linefillBuffer (
        .Clk           (Clk),
        .reset         (reset),
        .fillStart     (fillStart),
        .fillAddr      (fillAddr),
        .memBeatValid  (memBeatValid),
        .memBeatData   (memBeatData),
        .criticalValid (criticalValid),
        .criticalWord  (criticalWord),
        .lineDone      (lineDone),
        .line          (line),
        .lineAddr      (lineAddr)
    );

    lineStore #(
        .NumSets (NumSets)
    ) i_lineStore (
        .Clk        (Clk),
        .reset      (reset),
        .lookupAddr (lookupAddr),
        .installEn  (installEn),
        .lineAddr   (lineAddr),
        .line       (line),
        .hit        (hit),
        .hitWord    (hitWord)
    );

endmodule

/* dv/burstMemModel.sv */
module burstMemModel (
    input  logic                Clk,
    input  logic                reset,
    input  logic                memRead,
    input  refillPkg::wordAddrT memAddr,
    input  logic                stall,
    output logic                memBeatValid,
    output refillPkg::wordT     memBeatData,
    output logic                busy
);

    timeunit 1ns;
    timeprecision 100ps;

    // beats still owed for the open burst
    logic [3:0]          beatsLeft = '0;
    refillPkg::wordAddrT beatAddr  = '0;
    logic                beatValid = 1'b0;
    refillPkg::wordT     beatData  = '0;

    assign memBeatValid = beatValid;
    assign memBeatData  = beatData;
    assign busy         = (beatsLeft != '0);

    //////////////////////////////////////////////////
    // burst engine
    //////////////////////////////////////////////////

    always @(posedge Clk) begin
        if (reset) begin
            beatsLeft <= '0;
            beatValid <= 1'b0;
        end else begin
            beatValid <= 1'b0;
            if (memRead) begin
                // burst opens at the missed word
                beatsLeft <= 4'(refillPkg::wordsPerLine);
                beatAddr  <= memAddr;
            end else if (busy && !stall) begin
                beatValid <= 1'b1;
                // memory content is a fixed function of the address
                beatData  <= (beatAddr * 32'd40503) ^ 32'h5A5A5A5A;
                // wrap within the line
                beatAddr[2:0] <= beatAddr[2:0] + 3'd1;
                beatsLeft <= beatsLeft - 4'd1;
            end
        end
    end

endmodule

/* dv/refillTb.sv */
module refillTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumSets         = 16;
    localparam int SetBits         = $clog2(NumSets);
    localparam int ClkPeriod       = 8;
    localparam int NumRandom       = 40;
    localparam int SettleCycles    = 4;
    // eight beats, each gap at most one full LFSR run of ones
    localparam int WorstFillCycles = 8 * 17 + 8;
    localparam int MaxRequests     = 8 * 9 + 4 + 6 + 2 * NumRandom;
    localparam int TimeoutCycles   = MaxRequests * (WorstFillCycles + SettleCycles + 4);

    // one expected response
    typedef struct packed {
        refillPkg::wordAddrT addr;
        refillPkg::wordT     data;
        logic                hit;
        logic                timed;
    } expectT;

    logic                Clk       = 1'b0;
    logic                reset;
    logic                reqValid;
    refillPkg::reqT      req;
    logic                rspValid;
    refillPkg::rspT      rsp;
    logic                memRead;
    refillPkg::wordAddrT memAddr;
    logic                memBeatValid;
    refillPkg::wordT     memBeatData;
    logic                memBusy;
    logic                beatStall = 1'b0;

    logic [15:0] stimLfsr = 16'd56058;
    logic [15:0] gapLfsr  = 16'd56058;

    expectT              expQ [$];
    refillPkg::wordAddrT missQ [$];
    int                  reqCycles [$];
    int                  cycleNum       = 0;
    int                  valueErrors    = 0;
    int                  latencyErrors  = 0;
    int                  protocolErrors = 0;

    // which line each set holds, as the requester sees it
    logic                residentValid [NumSets];
    refillPkg::wordAddrT residentTag   [NumSets];

    always #(ClkPeriod / 2) Clk = ~Clk;

    refillTop #(
        .NumSets (NumSets)
    ) i_refillTop (
        .Clk          (Clk),
        .reset        (reset),
        .reqValid     (reqValid),
        .req          (req),
        .rspValid     (rspValid),
        .rsp          (rsp),
        .memRead      (memRead),
        .memAddr      (memAddr),
        .memBeatValid (memBeatValid),
        .memBeatData  (memBeatData)
    );

    burstMemModel i_burstMemModel (
        .Clk          (Clk),
        .reset        (reset),
        .memRead      (memRead),
        .memAddr      (memAddr),
        .stall        (beatStall),
        .memBeatValid (memBeatValid),
        .memBeatData  (memBeatData),
        .busy         (memBusy)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stimLfsr = lfsrStep(stimLfsr);
            v = {v[30:0], stimLfsr[0]};
        end
        return v;
    endfunction

    // reference memory content
    function automatic refillPkg::wordT memWord(input refillPkg::wordAddrT a);
        return (a * 32'd40503) ^ 32'h5A5A5A5A;
    endfunction

    function automatic int setOf(input refillPkg::wordAddrT a);
        return int'(a[refillPkg::offsetBits +: SetBits]);
    endfunction

    function automatic refillPkg::wordAddrT tagOf(input refillPkg::wordAddrT a);
        return a >> (refillPkg::offsetBits + SetBits);
    endfunction

    function automatic refillPkg::wordAddrT makeAddr(input int tag, input int setIdx,
                                                     input int off);
        return (refillPkg::wordAddrT'(tag) << (refillPkg::offsetBits + SetBits)) |
               (refillPkg::wordAddrT'(setIdx) << refillPkg::offsetBits) |
               refillPkg::wordAddrT'(off);
    endfunction

    // random beat gaps, one bit per cycle
    always @(posedge Clk) begin
        gapLfsr = lfsrStep(gapLfsr);
        beatStall <= gapLfsr[0];
    end

    //////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////

    // predict, then strobe one request
    task automatic sendRequest(input refillPkg::wordAddrT addr, input logic held,
                               output logic predictedHit);
        expectT want;
        int     setIdx;
        setIdx       = setOf(addr);
        predictedHit = residentValid[setIdx] && (residentTag[setIdx] == tagOf(addr));
        want.addr    = addr;
        want.data    = memWord(addr);
        want.hit     = predictedHit;
        want.timed   = !held;
        // a miss installs its line before any later request is served
        if (!predictedHit) begin
            missQ.push_back(addr);
            residentValid[setIdx] = 1'b1;
            residentTag[setIdx]   = tagOf(addr);
        end
        @(posedge Clk);
        expQ.push_back(want);
        reqValid <= 1'b1;
        req.addr <= addr;
        @(posedge Clk);
        reqValid <= 1'b0;
    endtask

    // all answers in and line installed
    task automatic waitQuiet();
        @(negedge Clk);
        while (expQ.size() != 0 || memBusy) begin
            @(negedge Clk);
        end
        repeat (SettleCycles) @(posedge Clk);
    endtask

    // second request lands while the first one's line is in flight
    task automatic heldPair(input refillPkg::wordAddrT first, input refillPkg::wordAddrT second,
                            input int gap);
        logic wasHit;
        sendRequest(first, 1'b0, wasHit);
        if (!wasHit) begin
            @(negedge Clk);
            while (!memRead) begin
                @(negedge Clk);
            end
            repeat (gap) @(posedge Clk);
            sendRequest(second, 1'b1, wasHit);
        end
        waitQuiet();
    endtask

    // miss at every offset, then read the whole line back
    task automatic fillEveryOffset();
        logic wasHit;
        int   tag;
        for (int off = 0; off < refillPkg::wordsPerLine; off++) begin
            tag = randBits(12);
            sendRequest(makeAddr(tag, off, off), 1'b0, wasHit);
            waitQuiet();
            for (int w = 0; w < refillPkg::wordsPerLine; w++) begin
                sendRequest(makeAddr(tag, off, w), 1'b0, wasHit);
            end
            waitQuiet();
        end
    endtask

    // same set, two tags
    task automatic evictionPair();
        logic wasHit;
        sendRequest(makeAddr(5, 9, 1), 1'b0, wasHit);
        waitQuiet();
        sendRequest(makeAddr(6, 9, 4), 1'b0, wasHit);
        waitQuiet();
        sendRequest(makeAddr(5, 9, 1), 1'b0, wasHit);
        waitQuiet();
        sendRequest(makeAddr(5, 9, 6), 1'b0, wasHit);
        waitQuiet();
    endtask

    // small pool of tags and sets, so hits and evictions both show up
    task automatic randomTraffic();
        refillPkg::wordAddrT a;
        refillPkg::wordAddrT b;
        int                  tag;
        int                  setIdx;
        int                  off;
        int                  gap;
        for (int i = 0; i < NumRandom; i++) begin
            tag    = randBits(2);
            setIdx = randBits(3);
            off    = randBits(3);
            a      = makeAddr(tag, setIdx, off);
            tag    = randBits(2);
            setIdx = randBits(3);
            off    = randBits(3);
            b      = makeAddr(tag, setIdx, off);
            gap    = randBits(3);
            if (randBits(1) == 32'd1) begin
                heldPair(a, b, gap);
            end else begin
                heldPair(a, a, gap);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        reset    = 1'b1;
        reqValid = 1'b0;
        req      = '0;
        for (int s = 0; s < NumSets; s++) begin
            residentValid[s] = 1'b0;
            residentTag[s]   = '0;
        end
        repeat (2) @(posedge Clk);
        reset <= 1'b0;
        repeat (2) @(posedge Clk);

        fillEveryOffset();
        evictionPair();
        // held hit in the filling line, held miss elsewhere, held miss in the same set
        heldPair(makeAddr(3, 12, 5), makeAddr(3, 12, 2), 2);
        heldPair(makeAddr(3, 13, 0), makeAddr(7, 14, 7), 5);
        heldPair(makeAddr(4, 15, 3), makeAddr(9, 15, 3), 0);
        randomTraffic();
        waitQuiet();

        assert (missQ.size() == 0) else begin
            protocolErrors++;
            $display("some misses never started a burst");
        end
        $display("errors: value %0d, latency %0d, protocol %0d",
                 valueErrors, latencyErrors, protocolErrors);
        if (valueErrors + latencyErrors + protocolErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    //////////////////////////////////////////////////
    // comparison, sampled mid cycle
    //////////////////////////////////////////////////

    always @(negedge Clk) begin : checkOutputs
        expectT              want;
        int                  reqCycle;
        refillPkg::wordAddrT wantAddr;
        if (!reset) begin
            cycleNum++;
            if (rspValid) begin
                assert (expQ.size() != 0) else begin
                    protocolErrors++;
                    $display("a response came with no request outstanding");
                end
                if (expQ.size() != 0) begin
                    want     = expQ.pop_front();
                    reqCycle = reqCycles.pop_front();
                    assert (rsp.hit == want.hit) else begin
                        valueErrors++;
                        $display("Fail %0t: hit for %h is %b, expected %b",
                                 $time, want.addr, rsp.hit, want.hit);
                    end
                    assert (rsp.data == want.data) else begin
                        valueErrors++;
                        $display("Fail %0t: data for %h is %h, expected %h",
                                 $time, want.addr, rsp.data, want.data);
                    end
                    // hits from idle answer on the next cycle
                    if (want.timed && want.hit) begin
                        assert (cycleNum == reqCycle + 1) else begin
                            latencyErrors++;
                            $display("Fail %0t: hit for %h took %0d cycles, expected 1",
                                     $time, want.addr, cycleNum - reqCycle);
                        end
                    end
                end
            end
            if (reqValid) begin
                reqCycles.push_back(cycleNum);
            end
            // one burst per miss, at the missed word
            if (memRead) begin
                assert (missQ.size() != 0) else begin
                    protocolErrors++;
                    $display("memory read started with no miss pending");
                end
                if (missQ.size() != 0) begin
                    wantAddr = missQ.pop_front();
                    assert (memAddr == wantAddr) else begin
                        valueErrors++;
                        $display("Fail %0t: memAddr is %h, expected %h",
                                 $time, memAddr, wantAddr);
                    end
                end
            end
        end
    end

    // watchdog
    initial begin
        #(TimeoutCycles * ClkPeriod);
        $display("the run did not finish in time");
        $display("errors: value %0d, latency %0d, protocol %0d",
                 valueErrors, latencyErrors, protocolErrors);
        $display("Something failed");
        $finish;
    end

endmodule

/* list.f */
hw/refillPkg.sv
hw/refillCtrl.sv
hw/linefillBuffer.sv
hw/lineStore.sv
hw/refillTop.sv
dv/burstMemModel.sv
dv/refillTb.sv

/* Makefile */
TOP = refillTb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o simv
	./obj_dir/simv > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Something failed" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf obj_dir $(LOG)
